/* Makefile */
# Verilator simulation of the divide unit

VERILATOR ?= verilator
TOP       ?= tb_div_unit
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/div_defines.svh */
`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

// ========================================
// datapath widths
// ========================================
`define DIV_XLEN 64          // operand and result width
`define DIV_TAG_W 5          // destination tag width

// ========================================
// queue depths and credits
// ========================================
`define DIV_REQ_DEPTH 2      // request slots, also upstream credits after reset
`define DIV_RSP_DEPTH 2      // response slots seen by the divider core
`define DIV_RSP_CREDITS 2    // credits granted by writeback after reset
`define DIV_CORE_CREDITS 1   // the core takes one request at a time

`endif

/* common/div_pkg.sv */
`default_nettype none

`include "div_defines.svh"

package div_pkg;

  // ========================================
  // operation encoding
  // ========================================
  // bit 2 selects remainder, bit 1 word width, bit 0 unsigned
  typedef enum logic [2:0] {
    OP_DIV   = 3'b000,
    OP_DIVU  = 3'b001,
    OP_DIVW  = 3'b010,
    OP_DIVUW = 3'b011,
    OP_REM   = 3'b100,
    OP_REMU  = 3'b101,
    OP_REMW  = 3'b110,
    OP_REMUW = 3'b111
  } div_op_e;

  typedef struct packed {
    div_op_e               op;
    logic [`DIV_XLEN-1:0]  dividend;
    logic [`DIV_XLEN-1:0]  divisor;
    logic [`DIV_TAG_W-1:0] tag;
  } div_req_t;  // 136 bits

  typedef struct packed {
    logic [`DIV_XLEN-1:0]  result;
    logic [`DIV_TAG_W-1:0] tag;
  } div_rsp_t;

  function automatic logic op_is_word(input div_op_e op);
    return op inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
  endfunction

  function automatic logic op_is_signed(input div_op_e op);
    return op inside {OP_DIV, OP_DIVW, OP_REM, OP_REMW};
  endfunction

  function automatic logic op_is_rem(input div_op_e op);
    return op inside {OP_REM, OP_REMU, OP_REMW, OP_REMUW};
  endfunction

endpackage

`default_nettype wire

/* divider/div_core.sv */
`default_nettype none

`include "div_defines.svh"

module div_core
  import div_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  in_valid_i,
  input  wire div_op_e               op_i,
  input  wire logic [`DIV_TAG_W-1:0] tag_i,
  input  wire logic                  word_i,
  input  wire logic                  q_neg_i,
  input  wire logic                  r_neg_i,
  input  wire logic [`DIV_XLEN-1:0]  dividend_abs_i,
  input  wire logic [`DIV_XLEN-1:0]  divisor_abs_i,
  input  wire logic                  except_i,
  input  wire logic [`DIV_XLEN-1:0]  except_result_i,
  output logic                       in_credit_o,
  output logic                       out_valid_o,
  output logic [`DIV_XLEN-1:0]       out_result_o,
  output logic [`DIV_TAG_W-1:0]      out_tag_o,
  input  wire logic                  out_credit_i
);

  localparam int XLEN  = `DIV_XLEN;
  localparam int HALF  = XLEN / 2;
  localparam int CNT_W = $clog2(XLEN + 1);
  localparam int CRD_W = $clog2(`DIV_RSP_DEPTH + 1);

  typedef enum logic [1:0] {
    IDLE,
    DO_DIV,
    FINISH
  } state_e;

  state_e                state;
  logic [CNT_W-1:0]      cnt;          // quotient bits left
  logic [2*XLEN-1:0]     rq;           // remainder:quotient
  logic [XLEN-1:0]       divisor;
  logic [`DIV_TAG_W-1:0] tag;
  logic                  word;
  logic                  is_rem;
  logic                  q_neg;
  logic                  r_neg;
  logic                  exc;
  logic [XLEN-1:0]       exc_result;
  logic [CRD_W-1:0]      rsp_credits;  // free response slots
  logic                  credit_q;
  logic                  accept;
  logic                  push;
  logic [XLEN+1:0]       diff;         // shifted remainder minus divisor, top bit is borrow
  logic [XLEN-1:0]       quo;
  logic [XLEN-1:0]       rem;
  logic [XLEN-1:0]       sel;

  assign accept = (state == IDLE) & in_valid_i;
  assign push   = (state == FINISH) & (rsp_credits != '0);

  // ========================================
  // control
  // ========================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state       <= IDLE;
      cnt         <= '0;
      credit_q    <= 1'b0;
      rsp_credits <= CRD_W'(`DIV_RSP_DEPTH);
    end else begin
      credit_q    <= push;  // pulses on the first IDLE cycle
      rsp_credits <= rsp_credits - CRD_W'(push) + CRD_W'(out_credit_i);
      case (state)
        IDLE: begin
          if (accept) begin
            state <= except_i ? FINISH : DO_DIV;  // exceptions skip iteration
            cnt   <= word_i ? CNT_W'(HALF) : CNT_W'(XLEN);
          end
        end
        DO_DIV: begin
          cnt <= cnt - 1'b1;
          if (cnt == CNT_W'(1)) begin
            state <= FINISH;
          end
        end
        FINISH: begin
          if (push) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ========================================
  // datapath
  // ========================================
  assign diff = {1'b0, rq[2*XLEN-1:XLEN-1]} - {2'b0, divisor};

  always_ff @(posedge clk) begin
    if (accept) begin
      rq         <= {{XLEN{1'b0}}, dividend_abs_i};
      divisor    <= divisor_abs_i;
      tag        <= tag_i;
      word       <= word_i;
      is_rem     <= op_is_rem(op_i);
      q_neg      <= q_neg_i;
      r_neg      <= r_neg_i;
      exc        <= except_i;
      exc_result <= except_result_i;
    end else if (state == DO_DIV) begin
      if (diff[XLEN+1]) begin
        rq <= {rq[2*XLEN-2:0], 1'b0};  // borrow, restore
      end else begin
        rq <= {diff[XLEN-1:0], rq[XLEN-2:0], 1'b1};
      end
    end
  end

  // sign fix-up
  assign quo = q_neg ? (~rq[XLEN-1:0] + 1'b1) : rq[XLEN-1:0];
  assign rem = r_neg ? (~rq[2*XLEN-1:XLEN] + 1'b1) : rq[2*XLEN-1:XLEN];
  assign sel = is_rem ? rem : quo;

  always_comb begin
    if (exc) begin
      out_result_o = exc_result;
    end else if (word) begin
      out_result_o = {{HALF{sel[HALF-1]}}, sel[HALF-1:0]};  // sext bit 31
    end else begin
      out_result_o = sel;
    end
  end

  assign out_valid_o = push;
  assign out_tag_o   = tag;
  assign in_credit_o = credit_q;

  // ========================================
  // checks
  // ========================================
  a_cnt_no_underflow: assert property (@(posedge clk) disable iff (rst_n)
    state == DO_DIV |-> cnt != '0);

  a_push_with_credit: assert property (@(posedge clk) disable iff (rst_n)
    out_valid_o |-> (rsp_credits != '0) && (rsp_credits <= CRD_W'(`DIV_RSP_DEPTH)));

endmodule

`default_nettype wire

/* divider/div_prep.sv */
`default_nettype none

`include "div_defines.svh"

module div_prep
  import div_pkg::*;
(
  input  wire div_op_e              op_i,
  input  wire logic [`DIV_XLEN-1:0] dividend_i,
  input  wire logic [`DIV_XLEN-1:0] divisor_i,
  output logic                      word_o,
  output logic                      q_neg_o,
  output logic                      r_neg_o,
  output logic [`DIV_XLEN-1:0]      dividend_abs_o,
  output logic [`DIV_XLEN-1:0]      divisor_abs_o,
  output logic                      except_o,
  output logic [`DIV_XLEN-1:0]      except_result_o
);

  localparam int XLEN = `DIV_XLEN;
  localparam int HALF = XLEN / 2;

  logic            is_word;
  logic            is_signed;
  logic            is_rem;
  logic [XLEN-1:0] a_ext;     // dividend at working width
  logic [XLEN-1:0] b_ext;     // divisor at working width
  logic [XLEN-1:0] a_arch;    // dividend as returned on exceptions
  logic [XLEN-1:0] a_abs;
  logic [XLEN-1:0] b_abs;
  logic [XLEN-1:0] min_neg;   // most negative value of the width
  logic            a_neg;
  logic            b_neg;
  logic            div_zero;
  logic            overflow;

  assign is_word   = op_is_word(op_i);
  assign is_signed = op_is_signed(op_i);
  assign is_rem    = op_is_rem(op_i);

  // ========================================
  // operand extension
  // ========================================
  always_comb begin
    if (!is_word) begin
      a_ext = dividend_i;
      b_ext = divisor_i;
    end else if (is_signed) begin
      a_ext = {{HALF{dividend_i[HALF-1]}}, dividend_i[HALF-1:0]};
      b_ext = {{HALF{divisor_i[HALF-1]}}, divisor_i[HALF-1:0]};
    end else begin
      a_ext = {{HALF{1'b0}}, dividend_i[HALF-1:0]};
      b_ext = {{HALF{1'b0}}, divisor_i[HALF-1:0]};
    end
  end

  // unsigned word ops still return a sign-extended dividend
  assign a_arch = is_word ? {{HALF{dividend_i[HALF-1]}}, dividend_i[HALF-1:0]} : dividend_i;

  // ========================================
  // signs and magnitudes
  // ========================================
  assign a_neg = is_signed & a_ext[XLEN-1];
  assign b_neg = is_signed & b_ext[XLEN-1];
  assign a_abs = a_neg ? (~a_ext + 1'b1) : a_ext;
  assign b_abs = b_neg ? (~b_ext + 1'b1) : b_ext;

  assign word_o  = is_word;
  assign q_neg_o = a_neg ^ b_neg;  // quotient sign
  assign r_neg_o = a_neg;          // remainder follows dividend

  // word dividend goes high so that 32 shifts reach the remainder half
  assign dividend_abs_o = is_word ? {a_abs[HALF-1:0], {HALF{1'b0}}} : a_abs;
  assign divisor_abs_o  = b_abs;

  // ========================================
  // divide-by-zero and signed overflow
  // ========================================
  assign min_neg  = is_word ? {{(HALF + 1){1'b1}}, {(HALF - 1){1'b0}}}
                            : {1'b1, {(XLEN - 1){1'b0}}};
  assign div_zero = (b_ext == '0);
  assign overflow = is_signed & (a_ext == min_neg) & (&b_ext);  // min / -1
  assign except_o = div_zero | overflow;

  always_comb begin
    if (div_zero) begin
      except_result_o = is_rem ? a_arch : '1;  // quotient is all ones
    end else if (overflow) begin
      except_result_o = is_rem ? '0 : a_arch;
    end else begin
      except_result_o = '0;
    end
  end

endmodule

`default_nettype wire

/* source/credit_fifo.sv */
`default_nettype none

module credit_fifo #(
  parameter type T       = logic,
  parameter int  DEPTH   = 2,
  parameter int  CREDITS = 2
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic push_valid_i,
  input  wire T     push_data_i,
  output logic      push_credit_o,
  output logic      pop_valid_o,
  output T          pop_data_o,
  input  wire logic pop_credit_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int CRD_W = $clog2(CREDITS + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;    // occupied slots
  logic [CRD_W-1:0] credits;  // downstream credits held
  logic             do_pop;

  // pop whenever there is an entry and somewhere to send it
  assign do_pop = (count != '0) & (credits != '0);

  // ========================================
  // pointers, occupancy and credits
  // ========================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= CRD_W'(CREDITS);
    end else begin
      if (push_valid_i) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count   <= count + CNT_W'(push_valid_i) - CNT_W'(do_pop);
      credits <= credits - CRD_W'(do_pop) + CRD_W'(pop_credit_i);
    end
  end

  always_ff @(posedge clk) begin
    if (push_valid_i) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  assign pop_valid_o   = do_pop;
  assign pop_data_o    = mem[rd_ptr];
  assign push_credit_o = do_pop;  // freed slot goes back upstream

  // ========================================
  // checks
  // ========================================
  a_no_push_when_full: assert property (@(posedge clk) disable iff (rst_n)
    push_valid_i |-> count < CNT_W'(DEPTH));

  a_credit_bound: assert property (@(posedge clk) disable iff (rst_n)
    credits <= CRD_W'(CREDITS));

endmodule

`default_nettype wire

/* source/div_unit.sv */
`default_nettype none

`include "div_defines.svh"

module div_unit
  import div_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  req_valid_i,
  input  wire div_op_e               req_op_i,
  input  wire logic [`DIV_XLEN-1:0]  req_dividend_i,
  input  wire logic [`DIV_XLEN-1:0]  req_divisor_i,
  input  wire logic [`DIV_TAG_W-1:0] req_tag_i,
  output logic                       req_credit_o,
  output logic                       rsp_valid_o,
  output logic [`DIV_XLEN-1:0]       rsp_result_o,
  output logic [`DIV_TAG_W-1:0]      rsp_tag_o,
  input  wire logic                  rsp_credit_i
);

  div_req_t              req_in;
  div_req_t              req_head;
  logic                  req_head_valid;
  logic                  core_credit;     // core back in IDLE
  logic                  word;
  logic                  q_neg;
  logic                  r_neg;
  logic                  exc;
  logic [`DIV_XLEN-1:0]  dividend_abs;
  logic [`DIV_XLEN-1:0]  divisor_abs;
  logic [`DIV_XLEN-1:0]  exc_result;
  logic                  core_valid;
  logic [`DIV_XLEN-1:0]  core_result;
  logic [`DIV_TAG_W-1:0] core_tag;
  logic                  rsp_slot_credit;  // response slot freed
  div_rsp_t              rsp_in;
  div_rsp_t              rsp_head;

  // ========================================
  // request side
  // ========================================
  assign req_in = '{op: req_op_i, dividend: req_dividend_i,
                    divisor: req_divisor_i, tag: req_tag_i};

  credit_fifo #(
    .T       (div_req_t),
    .DEPTH   (`DIV_REQ_DEPTH),
    .CREDITS (`DIV_CORE_CREDITS)
  ) u_req_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .push_valid_i  (req_valid_i),
    .push_data_i   (req_in),
    .push_credit_o (req_credit_o),
    .pop_valid_o   (req_head_valid),
    .pop_data_o    (req_head),
    .pop_credit_i  (core_credit)
  );

  div_prep u_prep (
    .op_i            (req_head.op),
    .dividend_i      (req_head.dividend),
    .divisor_i       (req_head.divisor),
    .word_o          (word),
    .q_neg_o         (q_neg),
    .r_neg_o         (r_neg),
    .dividend_abs_o  (dividend_abs),
    .divisor_abs_o   (divisor_abs),
    .except_o        (exc),
    .except_result_o (exc_result)
  );

  div_core u_core (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid_i      (req_head_valid),
    .op_i            (req_head.op),
    .tag_i           (req_head.tag),
    .word_i          (word),
    .q_neg_i         (q_neg),
    .r_neg_i         (r_neg),
    .dividend_abs_i  (dividend_abs),
    .divisor_abs_i   (divisor_abs),
    .except_i        (exc),
    .except_result_i (exc_result),
    .in_credit_o     (core_credit),
    .out_valid_o     (core_valid),
    .out_result_o    (core_result),
    .out_tag_o       (core_tag),
    .out_credit_i    (rsp_slot_credit)
  );

  // ========================================
  // response side
  // ========================================
  assign rsp_in = '{result: core_result, tag: core_tag};

  credit_fifo #(
    .T       (div_rsp_t),
    .DEPTH   (`DIV_RSP_DEPTH),
    .CREDITS (`DIV_RSP_CREDITS)
  ) u_rsp_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .push_valid_i  (core_valid),
    .push_data_i   (rsp_in),
    .push_credit_o (rsp_slot_credit),
    .pop_valid_o   (rsp_valid_o),
    .pop_data_o    (rsp_head),
    .pop_credit_i  (rsp_credit_i)
  );

  assign rsp_result_o = rsp_head.result;
  assign rsp_tag_o    = rsp_head.tag;

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
+incdir+test
common/div_pkg.sv
source/credit_fifo.sv
divider/div_prep.sv
divider/div_core.sv
source/div_unit.sv
test/tb_div_unit.sv

/* test/div_model.svh */
`ifndef DIV_MODEL_SVH
`define DIV_MODEL_SVH

// ========================================
// reference division rules
// ========================================
function automatic logic [63:0] sign_extend_word(input logic [31:0] v);
  return {{32{v[31]}}, v};
endfunction

// 64-bit divide with the architectural zero and overflow results
function automatic logic [63:0] quot_rem64(input logic sgn, input logic is_rem,
                                            input logic [63:0] a, input logic [63:0] b);
  logic signed [63:0] sa;
  logic signed [63:0] sb;
  sa = a;
  sb = b;
  if (b == 64'd0) return is_rem ? a : {64{1'b1}};         // divide by zero
  if (sgn && a == {1'b1, 63'd0} && b == {64{1'b1}}) begin
    return is_rem ? 64'd0 : a;                            // min / -1
  end
  if (sgn) return is_rem ? (sa % sb) : (sa / sb);         // truncates toward zero
  return is_rem ? (a % b) : (a / b);
endfunction

// same rules on the low words, result still 32 bits
function automatic logic [31:0] quot_rem32(input logic sgn, input logic is_rem,
                                            input logic [31:0] a, input logic [31:0] b);
  logic signed [31:0] sa;
  logic signed [31:0] sb;
  sa = a;
  sb = b;
  if (b == 32'd0) return is_rem ? a : {32{1'b1}};
  if (sgn && a == {1'b1, 31'd0} && b == {32{1'b1}}) return is_rem ? 32'd0 : a;
  if (sgn) return is_rem ? (sa % sb) : (sa / sb);
  return is_rem ? (a % b) : (a / b);
endfunction

function automatic logic [`DIV_XLEN-1:0] expected_result(input div_op_e op,
                                                         input logic [`DIV_XLEN-1:0] a,
                                                         input logic [`DIV_XLEN-1:0] b);
  logic word;
  logic is_rem;
  logic sgn;
  case (op)
    OP_DIV:   {word, is_rem, sgn} = 3'b001;
    OP_DIVU:  {word, is_rem, sgn} = 3'b000;
    OP_DIVW:  {word, is_rem, sgn} = 3'b101;
    OP_DIVUW: {word, is_rem, sgn} = 3'b100;
    OP_REM:   {word, is_rem, sgn} = 3'b011;
    OP_REMU:  {word, is_rem, sgn} = 3'b010;
    OP_REMW:  {word, is_rem, sgn} = 3'b111;
    default:  {word, is_rem, sgn} = 3'b110;  // remuw
  endcase
  if (word) return sign_extend_word(quot_rem32(sgn, is_rem, a[31:0], b[31:0]));
  return quot_rem64(sgn, is_rem, a, b);
endfunction

`endif

/* test/tb_div_unit.sv */
`default_nettype none

`include "div_defines.svh"

module tb_div_unit
  import div_pkg::*;
();

  localparam int MAX_REQ        = 128;
  localparam int SETTLE         = 150;  // cycles for the stalled pipe to go quiet
  localparam int FLOOD          = `DIV_REQ_DEPTH + `DIV_RSP_DEPTH + `DIV_RSP_CREDITS
                                  + `DIV_CORE_CREDITS;
  localparam int TIMEOUT_CYCLES = MAX_REQ * 80 + 2 * SETTLE + 500;

  logic                  clk;
  logic                  rst_n;
  logic                  req_valid_i    = 1'b0;
  div_op_e               req_op_i       = OP_DIV;
  logic [`DIV_XLEN-1:0]  req_dividend_i = '0;
  logic [`DIV_XLEN-1:0]  req_divisor_i  = '0;
  logic [`DIV_TAG_W-1:0] req_tag_i      = '0;
  logic                  req_credit_o;
  logic                  rsp_valid_o;
  logic [`DIV_XLEN-1:0]  rsp_result_o;
  logic [`DIV_TAG_W-1:0] rsp_tag_o;
  logic                  rsp_credit_i   = 1'b0;

  // request table, index doubles as the tag
  div_op_e               stim_op       [MAX_REQ];
  logic [`DIV_XLEN-1:0]  stim_dividend [MAX_REQ];
  logic [`DIV_XLEN-1:0]  stim_divisor  [MAX_REQ];
  logic [`DIV_XLEN-1:0]  exp_result    [MAX_REQ];

  int          stim_count          = 0;
  int          sent_count          = 0;
  int          rsp_seen            = 0;
  int          req_credit_seen     = 0;
  int          credits_given       = 0;  // writeback credits returned
  int          dut_rsp_credits     = `DIV_RSP_CREDITS;
  int          sends_before_credit = 0;
  int          check_errors        = 0;
  int          other_errors        = 0;
  int          cycle_count         = 0;
  logic        hold_credits        = 1'b0;
  logic [31:0] lcg_state           = 32'd94;

  `include "div_model.svh"

  div_unit uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid_i),
    .req_op_i       (req_op_i),
    .req_dividend_i (req_dividend_i),
    .req_divisor_i  (req_divisor_i),
    .req_tag_i      (req_tag_i),
    .req_credit_o   (req_credit_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_result_o   (rsp_result_o),
    .rsp_tag_o      (rsp_tag_o),
    .rsp_credit_i   (rsp_credit_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ========================================
  // helpers
  // ========================================
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int upstream_credits();
    return `DIV_REQ_DEPTH + req_credit_seen - sent_count;
  endfunction

  task automatic check_result(input string name, input logic [`DIV_XLEN-1:0] got,
                              input logic [`DIV_XLEN-1:0] exp);
    if (got !== exp) begin
      check_errors++;
      $display("CHECK FAILED time=%0t %s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  task automatic check_tag(input string name, input logic [`DIV_TAG_W-1:0] got,
                           input logic [`DIV_TAG_W-1:0] exp);
    if (got !== exp) begin
      check_errors++;
      $display("CHECK FAILED time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      check_errors++;
      $display("CHECK FAILED time=%0t %s got=%b expected=%b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      check_errors++;
      $display("CHECK FAILED time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
    end
  endtask

  task automatic queue_req(input div_op_e op, input logic [`DIV_XLEN-1:0] a,
                           input logic [`DIV_XLEN-1:0] b);
    if (stim_count >= MAX_REQ) begin
      other_errors++;
      $display("request table is full, a request was dropped");
    end else begin
      stim_op[stim_count]       = op;
      stim_dividend[stim_count] = a;
      stim_divisor[stim_count]  = b;
      exp_result[stim_count]    = expected_result(op, a, b);
      stim_count++;
    end
  endtask

  task automatic wait_idle();
    while (sent_count < stim_count || rsp_seen < sent_count || credits_given < rsp_seen) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);  // last writeback credit lands
  endtask

  // ========================================
  // upstream driver, writeback and monitor
  // ========================================
  always @(posedge clk) begin
    if (rst_n) begin
      req_valid_i <= 1'b0;
    end else if (sent_count < stim_count && upstream_credits() > 0) begin
      req_valid_i    <= 1'b1;
      req_op_i       <= stim_op[sent_count];
      req_dividend_i <= stim_dividend[sent_count];
      req_divisor_i  <= stim_divisor[sent_count];
      req_tag_i      <= `DIV_TAG_W'(sent_count);
      if (req_credit_seen == 0) begin
        sends_before_credit++;
      end
      sent_count++;
    end else begin
      req_valid_i <= 1'b0;
    end
  end

  // one credit back per response unless writeback is stalled
  always @(posedge clk) begin
    if (rst_n) begin
      rsp_credit_i <= 1'b0;
    end else if (!hold_credits && credits_given < rsp_seen) begin
      rsp_credit_i <= 1'b1;
      credits_given++;
    end else begin
      rsp_credit_i <= 1'b0;
    end
  end

  always @(negedge clk) begin
    if (!rst_n) begin
      if (req_credit_o) begin
        req_credit_seen++;
        if (upstream_credits() > `DIV_REQ_DEPTH) begin
          other_errors++;
          $display("time=%0t more request credits came back than requests sent", $time);
        end
      end
      if (rsp_valid_o) begin
        if (dut_rsp_credits == 0) begin
          other_errors++;
          $display("time=%0t response sent without a writeback credit", $time);
        end
        dut_rsp_credits--;
        if (rsp_seen >= sent_count) begin
          other_errors++;
          $display("time=%0t response arrived with no request outstanding", $time);
        end else begin
          check_result("rsp_result_o", rsp_result_o, exp_result[rsp_seen]);
          check_tag("rsp_tag_o", rsp_tag_o, `DIV_TAG_W'(rsp_seen));
        end
        rsp_seen++;
      end
      if (rsp_credit_i) begin
        dut_rsp_credits++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ========================================
  // directed tests
  // ========================================
  task automatic reset_credit_test();
    int i;
    check_bit("req_credit_o", req_credit_o, 1'b0);
    check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
    for (i = 0; i <= `DIV_REQ_DEPTH; i++) begin
      queue_req(OP_DIVU, 64'd1000 + 64'(i), 64'd7);
    end
    wait_idle();
    check_count("requests sent before first credit", sends_before_credit, `DIV_REQ_DEPTH);
    check_count("request credits returned", req_credit_seen, sent_count);
  endtask

  task automatic all_ops_test();
    logic [`DIV_XLEN-1:0] a_vals [3];
    logic [`DIV_XLEN-1:0] b_vals [3];
    int i;
    int j;
    a_vals = '{64'd1000, 64'hFFFF_FFFF_FFFF_FF9C, 64'h1234_5678_FFFF_FF9C};
    b_vals = '{64'd7, 64'd7, 64'hABCD_0000_FFFF_FFF9};  // last pair negative low words
    for (i = 0; i < 8; i++) begin
      for (j = 0; j < 3; j++) begin
        queue_req(div_op_e'(3'(i)), a_vals[j], b_vals[j]);
      end
    end
    wait_idle();
  endtask

  task automatic exception_test();
    logic [`DIV_XLEN-1:0] a_vals [4];
    logic [`DIV_XLEN-1:0] b_vals [4];
    int i;
    int j;
    a_vals = '{64'h0123_4567_89AB_CDEF, 64'hFEDC_BA98_8765_4321,
               64'h8000_0000_0000_0000, 64'h0000_0000_8000_0000};
    b_vals = '{64'd0, 64'hFFFF_FFFF_0000_0000,   // zero at both widths, then word only
               64'hFFFF_FFFF_FFFF_FFFF, 64'h0000_0000_FFFF_FFFF};
    for (i = 0; i < 8; i++) begin
      for (j = 0; j < 4; j++) begin
        queue_req(div_op_e'(3'(i)), a_vals[j], b_vals[j]);
      end
    end
    wait_idle();
  endtask

  task automatic random_test();
    logic [31:0]          r;
    logic [`DIV_XLEN-1:0] a;
    logic [`DIV_XLEN-1:0] b;
    int i;
    for (i = 0; i < 40; i++) begin
      r = lcg_next();
      a = {lcg_next(), lcg_next()};
      b = {lcg_next(), lcg_next()};
      case (r[27:26])
        2'd0: b = {60'd0, r[25:22]} + 64'd1;      // small divisor
        2'd1: b = -({60'd0, r[25:22]} + 64'd1);   // small negative
        2'd2: begin
          b[63] = 1'b1;
          b[31] = 1'b1;
        end
        default: ;
      endcase
      if (r[21]) begin
        a[63] = 1'b1;
        a[31] = 1'b1;
      end
      queue_req(div_op_e'(r[30:28]), a, b);
    end
    wait_idle();
  endtask

  task automatic backpressure_test();
    int credit_mark;
    int rsp_mark;
    int stalled_credits;
    int i;
    hold_credits    = 1'b1;
    credit_mark     = req_credit_seen;
    rsp_mark        = rsp_seen;
    for (i = 0; i < FLOOD; i++) begin
      queue_req(div_op_e'(3'(i)), 64'h0F0F_0000_1234_5678 + 64'(i * 977), 64'd3 + 64'(i));
    end
    while (sent_count < stim_count) begin
      @(negedge clk);
    end
    repeat (SETTLE) @(negedge clk);
    stalled_credits = req_credit_seen;
    repeat (SETTLE) @(negedge clk);
    check_count("request credits while stalled", req_credit_seen, stalled_credits);
    check_count("request credits before stall", req_credit_seen - credit_mark,
                FLOOD - `DIV_REQ_DEPTH);
    check_count("responses while credits withheld", rsp_seen - rsp_mark, `DIV_RSP_CREDITS);
    check_count("upstream credits while stalled", upstream_credits(), 0);
    hold_credits = 1'b0;  // release, everything drains in order
    wait_idle();
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    rst_n = 1'b1;
    repeat (4) @(posedge clk);
    rst_n <= 1'b0;
    @(negedge clk);
    reset_credit_test();
    all_ops_test();
    exception_test();
    random_test();
    backpressure_test();
    check_count("request credits returned", req_credit_seen, sent_count);
    check_count("writeback credits held by DUT", dut_rsp_credits, `DIV_RSP_CREDITS);
    $display("errors: %0d value mismatches, %0d other failures, %0d responses",
             check_errors, other_errors, rsp_seen);
    if (check_errors == 0 && other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
